// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tart_tb -f tart.f -o tart_sim
out=$(./obj_dir/tart_sim)
echo "$out"

if grep -qx "Everything OK" <<< "$out"; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== src/tart_aq_buffer.sv ====
`timescale 1ns/10ps

module tart_aq_buffer #(
   parameter int AQ_DEPTH = 16,                        // Words, power of two
   parameter int CW       = $clog2(AQ_DEPTH) + 1       // Count width
) (
   input  logic              clk_x,
   input  logic              reset,
   input  logic              soft_rst_i,
   input  logic              enable_i,
   input  tart_pkg::sample_t sample_i,
   input  logic              strobe_i,
   input  logic              advance_i,
   output tart_pkg::sample_t head_o,
   output logic              full_o,
   output logic [CW-1:0]     count_o
);
   import tart_pkg::*;

   localparam int AW = $clog2(AQ_DEPTH);

   sample_t       mem [AQ_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          full;
   logic          at_depth;  // Last word written, full follows
   logic          clr;
   logic          wr_en;

   assign clr      = reset | soft_rst_i;
   assign at_depth = (count == CW'(AQ_DEPTH));

   // Strobes dropped while full or about to be
   assign wr_en = strobe_i & enable_i & ~full & ~at_depth & ~clr;

   // ------------------------------
   // Sample storage
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (wr_en)
         mem[wr_ptr] <= sample_i;
   end

   assign head_o = mem[rd_ptr];  // No read latency

   // ------------------------------
   // Fill, drain and re-arm
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (clr) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full   <= 1'b0;
      end else if (full) begin
         // Drain phase, host pulls words out
         if (advance_i) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (rd_ptr == AW'(AQ_DEPTH - 1)) begin
               count <= '0;   // Last word gone, ready to refill
               full  <= 1'b0;
            end
         end
      end else if (at_depth) begin
         full <= 1'b1;        // One cycle after count hits depth
      end else if (wr_en) begin
         wr_ptr <= wr_ptr + 1'b1;  // Wraps to zero on the last word
         count  <= count + 1'b1;
      end
   end

   assign full_o  = full;
   assign count_o = count;

endmodule

// ==== src/tart_capture.sv ====
`timescale 1ns/10ps

module tart_capture #(
   parameter int SAMPLE_DIV = 8  // Clocks per sample period
) (
   input  logic               clk_x,
   input  logic               reset,
   input  logic               soft_rst_i,
   input  tart_pkg::sample_t  antenna_i,
   input  tart_pkg::aq_ctrl_t ctrl_i,
   output tart_pkg::sample_t  sample_o,
   output logic               strobe_o
);
   import tart_pkg::*;

   localparam int PW = $clog2(SAMPLE_DIV);

   sample_t       ant_q;    // IO register for the antenna bus
   sample_t       dbg_cnt;  // Fake telescope source
   sample_t       sample_q;
   logic [PW-1:0] phase;
   logic          strobe_q;
   logic          hit;      // Phase matches the programmed delay
   logic          clr;

   assign clr = reset | soft_rst_i;
   assign hit = (phase == PW'(ctrl_i.delay));

   // Antenna pins registered on every edge
   always_ff @(posedge clk_x) begin
      ant_q <= antenna_i;
   end

   // ------------------------------
   // Sample period and strobe
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (clr) begin
         phase    <= '0;
         strobe_q <= 1'b0;
      end else begin
         strobe_q <= hit;                             // One cycle per period
         if (phase == PW'(SAMPLE_DIV - 1))
            phase <= '0;                              // Wrap at period end
         else
            phase <= phase + 1'b1;
      end
   end

   // Debug counter steps once per strobe
   always_ff @(posedge clk_x) begin
      if (clr)
         dbg_cnt <= '0;
      else if (hit)
         dbg_cnt <= dbg_cnt + 1'b1;
   end

   // Sample taken in the strobe cycle, held until the next one
   always_ff @(posedge clk_x) begin
      if (hit)
         sample_q <= ctrl_i.debug ? dbg_cnt : ant_q;  // Source select
   end

   assign sample_o = sample_q;
   assign strobe_o = strobe_q;

endmodule

// ==== src/tart_pkg.sv ====
// ------------------------------
// Shared types and constants for the capture core
// ------------------------------
package tart_pkg;

   // Bus and data widths
   localparam int ANT_WIDTH = 24;       // One bit per antenna
   localparam int APB_AW    = 4;
   localparam int APB_DW    = 32;
   localparam int DELAY_W   = 3;        // Strobe position within sample period

   // Register map, byte addresses
   localparam logic [APB_AW-1:0] ADDR_DATA   = 4'h0;  // Buffer read-back, RO
   localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h4;  // Control bits, RW
   localparam logic [APB_AW-1:0] ADDR_STATUS = 4'h8;  // Status word, RO
   localparam logic [APB_AW-1:0] ADDR_RESET  = 4'hC;  // Any write resets core

   // ------------------------------
   // APB channels
   // ------------------------------

   // Master to slave
   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [APB_AW-1:0] paddr;
      logic [APB_DW-1:0] pwdata;
   } apb_req_t;

   // Slave to master
   typedef struct packed {
      logic [APB_DW-1:0] prdata;
      logic              pready;
      logic              pslverr;
   } apb_rsp_t;

   // ------------------------------
   // Acquisition control and status
   // ------------------------------

   // CTRL register layout, enable in bit 4
   typedef struct packed {
      logic               enable;  // Start filling the buffer
      logic               debug;   // Counter source instead of antennas
      logic [DELAY_W-1:0] delay;   // Phase of the sample strobe
   } aq_ctrl_t;

   // STATUS register layout, upper bits read as zero
   typedef struct packed {
      logic       enabled;
      logic       full;
      logic [7:0] count;           // Words held in the buffer
   } aq_status_t;

   typedef logic [ANT_WIDTH-1:0] sample_t;

endpackage

// ==== src/tart_regs.sv ====
`timescale 1ns/10ps

module tart_regs #(
   parameter int AQ_DEPTH = 16,
   parameter int CW       = $clog2(AQ_DEPTH) + 1
) (
   input  logic               clk_x,
   input  logic               reset,
   input  tart_pkg::apb_req_t apb_req_i,
   output tart_pkg::apb_rsp_t apb_rsp_o,
   input  tart_pkg::sample_t  head_i,
   input  logic               full_i,
   input  logic [CW-1:0]      count_i,
   output tart_pkg::aq_ctrl_t ctrl_o,
   output logic               advance_o,
   output logic               soft_rst_o
);
   import tart_pkg::*;

   localparam int CTRL_W = $bits(aq_ctrl_t);

   aq_ctrl_t          ctrl_q;
   aq_status_t        status;
   logic [2:0]        rst_cnt;   // Soft-reset cycles left
   logic              access;
   logic              wr_acc;
   logic              rd_acc;
   logic              addr_ok;
   logic [APB_DW-1:0] rdata;

   // ------------------------------
   // APB decode
   // ------------------------------
   assign access = apb_req_i.psel & apb_req_i.penable;  // Second cycle
   assign wr_acc = access & apb_req_i.pwrite;
   assign rd_acc = access & ~apb_req_i.pwrite;

   always_comb begin
      case (apb_req_i.paddr)
         ADDR_DATA, ADDR_CTRL, ADDR_STATUS, ADDR_RESET: addr_ok = 1'b1;
         default:                                       addr_ok = 1'b0;
      endcase
   end

   // ------------------------------
   // Control register
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (reset || soft_rst_o)
         ctrl_q <= '0;
      else if (wr_acc && apb_req_i.paddr == ADDR_CTRL)
         ctrl_q <= aq_ctrl_t'(apb_req_i.pwdata[CTRL_W-1:0]);
   end

   assign ctrl_o = ctrl_q;

   // Status word from buffer state
   always_comb begin
      status.enabled = ctrl_q.enable;
      status.full    = full_i;
      status.count   = 8'(count_i);  // Zero-extended
   end

   // Read mux
   always_comb begin
      case (apb_req_i.paddr)
         ADDR_DATA:   rdata = full_i ? APB_DW'(head_i) : '0;  // Zero until full
         ADDR_CTRL:   rdata = APB_DW'(ctrl_q);
         ADDR_STATUS: rdata = APB_DW'(status);
         default:     rdata = '0;
      endcase
   end

   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = access;            // No wait states
   assign apb_rsp_o.pslverr = access & ~addr_ok;

   // Pop the head on each data read while full
   assign advance_o = rd_acc & full_i & (apb_req_i.paddr == ADDR_DATA);

   // ------------------------------
   // Soft reset stretcher
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (reset)
         rst_cnt <= '0;
      else if (wr_acc && apb_req_i.paddr == ADDR_RESET)
         rst_cnt <= 3'd4;                // Four cycles of reset
      else if (rst_cnt != '0)
         rst_cnt <= rst_cnt - 1'b1;
   end

   assign soft_rst_o = (rst_cnt != '0);

endmodule

// ==== src/tart_top.sv ====
`timescale 1ns/10ps

module tart_top #(
   parameter int AQ_DEPTH   = 16,  // Buffer words, power of two up to 128
   parameter int SAMPLE_DIV = 8    // Clocks per sample, 8 or more
) (
   input  logic               clk_x,
   input  logic               reset,
   input  tart_pkg::apb_req_t apb_req_i,
   output tart_pkg::apb_rsp_t apb_rsp_o,
   input  tart_pkg::sample_t  antenna_i
);
   import tart_pkg::*;

   localparam int CW = $clog2(AQ_DEPTH) + 1;

   aq_ctrl_t      ctrl;
   sample_t       sample;
   sample_t       head;
   logic          strobe;
   logic          full;
   logic [CW-1:0] count;
   logic          advance;
   logic          soft_rst;

   // ------------------------------
   // Antenna capture
   // ------------------------------
   tart_capture #(.SAMPLE_DIV(SAMPLE_DIV)) capture_i (
      .clk_x      (clk_x),
      .reset      (reset),
      .soft_rst_i (soft_rst),
      .antenna_i  (antenna_i),
      .ctrl_i     (ctrl),
      .sample_o   (sample),
      .strobe_o   (strobe)
   );

   // Acquisition buffer
   tart_aq_buffer #(.AQ_DEPTH(AQ_DEPTH), .CW(CW)) aq_buffer_i (
      .clk_x      (clk_x),
      .reset      (reset),
      .soft_rst_i (soft_rst),
      .enable_i   (ctrl.enable),
      .sample_i   (sample),
      .strobe_i   (strobe),
      .advance_i  (advance),
      .head_o     (head),
      .full_o     (full),
      .count_o    (count)
   );

   // Host register bank
   tart_regs #(.AQ_DEPTH(AQ_DEPTH), .CW(CW)) regs_i (
      .clk_x      (clk_x),
      .reset      (reset),
      .apb_req_i  (apb_req_i),
      .apb_rsp_o  (apb_rsp_o),
      .head_i     (head),
      .full_i     (full),
      .count_i    (count),
      .ctrl_o     (ctrl),
      .advance_o  (advance),
      .soft_rst_o (soft_rst)
   );

endmodule

// ==== tart.f ====
src/tart_pkg.sv
src/tart_capture.sv
src/tart_aq_buffer.sv
src/tart_regs.sv
src/tart_top.sv
tb/tart_tb.sv

// ==== tb/tart_golden.txt ====
// Columns: step code, antenna word, CTRL value, expected word (hex)
// Codes: 0 reset state, 1 CTRL write and read, 2 unmapped read, 3 antenna capture,
//        4 debug capture, 5 DATA read while not full, 6 soft reset while filling
0 000000 00 00000000
1 000000 05 00000005
1 000000 0a 0000000a
1 000000 17 00000017
1 000000 00 00000000
2 000000 00 00000000
3 a5c3f0 10 00a5c3f0
3 5a3c0f 10 005a3c0f
4 000000 18 00000000
5 000000 10 00000000
6 000000 10 00000000
3 ffffff 10 00ffffff

// ==== tb/tart_tb.sv ====
`timescale 1ns/10ps

module tart_tb;
   import tart_pkg::*;

   localparam int AQ_DEPTH   = 16;
   localparam int SAMPLE_DIV = 8;
   localparam int N_STEPS    = 12;                                   // Lines in golden file
   localparam int LIMIT      = 40 * AQ_DEPTH * SAMPLE_DIV * N_STEPS;
   localparam logic [APB_AW-1:0] ADDR_NONE = 4'h2;                  // Unmapped address
   localparam logic [APB_DW-1:0] EN_BIT    = 32'h10;                // CTRL enable
   localparam sample_t           PART_ANT  = 24'h3c5a96;            // Nonzero partial-fill word

   logic        clk_x = 1'b0;
   logic        reset;
   apb_req_t    req;
   apb_rsp_t    rsp;
   sample_t     antenna;
   logic [31:0] gold [4*N_STEPS];  // Code, antenna, ctrl, expected per step
   int          errors;
   int          cycles;

   tart_top #(.AQ_DEPTH(AQ_DEPTH), .SAMPLE_DIV(SAMPLE_DIV)) dut_i (
      .clk_x     (clk_x),
      .reset     (reset),
      .apb_req_i (req),
      .apb_rsp_o (rsp),
      .antenna_i (antenna)
   );

   always #5 clk_x = ~clk_x;  // 10 ns period

   // Run limit
   always @(posedge clk_x) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout, test still running after %0d cycles", cycles);
         $display("Something failed");
         $finish;
      end
   end

   task automatic flag_error(input string msg);
      $display("FAIL t=%0t: %s", $time, msg);
      errors++;
   endtask

   // ------------------------------
   // APB master
   // ------------------------------
   task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                           input logic [APB_DW-1:0] wdata,
                           output logic [APB_DW-1:0] rdata, output logic err);
      @(negedge clk_x);
      req.psel    = 1'b1;  // Setup cycle
      req.penable = 1'b0;
      req.pwrite  = wr;
      req.paddr   = addr;
      req.pwdata  = wdata;
      @(negedge clk_x);
      req.penable = 1'b1;  // Access cycle
      #1;
      rdata = rsp.prdata;
      err   = rsp.pslverr;
      if (!rsp.pready)
         flag_error("pready low in access cycle");
      @(negedge clk_x);
      req = '0;
   endtask

   task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
      logic [APB_DW-1:0] d;
      logic              e;
      apb_xfer(1'b1, addr, data, d, e);
      if (e)
         flag_error($sformatf("pslverr on write to %h", addr));
   endtask

   task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
      logic e;
      apb_xfer(1'b0, addr, '0, data, e);
      if (e)
         flag_error($sformatf("pslverr on read from %h", addr));
   endtask

   // Empty buffer, CTRL cleared
   task automatic clean_start();
      write_reg(ADDR_RESET, '0);
      repeat (5) @(negedge clk_x);
   endtask

   // Poll STATUS for full, or for a nonzero count
   task automatic wait_status(input logic want_full, output logic [31:0] s);
      read_reg(ADDR_STATUS, s);
      while (want_full ? !s[8] : (s[7:0] == 8'd0))
         read_reg(ADDR_STATUS, s);
   endtask

   // ------------------------------
   // Fill and drain one buffer
   // ------------------------------
   task automatic capture_run(input sample_t ant, input logic [31:0] ctl, exp, input logic dbg);
      logic [31:0] dly;
      logic [31:0] w;
      logic [31:0] prev;
      logic [31:0] s;
      dly     = $urandom % 8;                         // Random strobe phase
      antenna = ant;
      repeat (3) @(negedge clk_x);                    // Input register settles
      write_reg(ADDR_CTRL, (ctl & ~EN_BIT) | dly);    // Source first
      write_reg(ADDR_CTRL, ctl | dly);
      wait_status(1'b1, s);
      write_reg(ADDR_CTRL, (ctl & ~EN_BIT) | dly);    // No refill after drain
      prev = '0;
      for (int i = 0; i < AQ_DEPTH; i++) begin
         read_reg(ADDR_DATA, w);
         if (!dbg && w !== exp)
            flag_error($sformatf("DATA word %0d is %h, expected %h", i, w, exp));
         if (dbg && i > 0 && w !== prev + 1)
            flag_error($sformatf("Debug word %0d is %h after %h", i, w, prev));
         prev = w;
      end
      read_reg(ADDR_STATUS, s);
      if (s[8] || s[7:0] != 8'd0)
         flag_error($sformatf("STATUS %h after drain, expected full low and count zero", s));
   endtask

   initial begin
      logic [31:0] code, ant, ctl, exp, r, s;
      logic        e;
      r       = $urandom(91);  // Seed
      errors  = 0;
      reset   = 1'b1;
      req     = '0;
      antenna = '0;
      $readmemh("tb/tart_golden.txt", gold);
      repeat (2) @(posedge clk_x);
      @(negedge clk_x);
      reset = 1'b0;
      for (int k = 0; k < N_STEPS; k++) begin
         code = gold[4*k];
         ant  = gold[4*k+1];
         ctl  = gold[4*k+2];
         exp  = gold[4*k+3];
         case (code)
            0: begin  // State after reset
               read_reg(ADDR_STATUS, r);
               if (r !== exp)
                  flag_error($sformatf("STATUS %h after reset, expected %h", r, exp));
               read_reg(ADDR_CTRL, r);
               if (r !== exp)
                  flag_error($sformatf("CTRL %h after reset, expected %h", r, exp));
            end
            1: begin
               write_reg(ADDR_CTRL, ctl);
               read_reg(ADDR_CTRL, r);
               if (r !== exp)
                  flag_error($sformatf("CTRL reads %h, expected %h", r, exp));
            end
            2: begin
               apb_xfer(1'b0, ADDR_NONE, '0, r, e);
               if (e !== 1'b1)
                  flag_error("No pslverr at unmapped address");
               if (r !== exp)
                  flag_error($sformatf("Unmapped read %h, expected %h", r, exp));
            end
            3, 4: begin
               clean_start();
               capture_run(ant[ANT_WIDTH-1:0], ctl, exp, code == 4);
            end
            5: begin  // Partial buffer, frozen
               clean_start();
               antenna = PART_ANT;                 // Head word must differ from zero
               write_reg(ADDR_CTRL, ctl);
               wait_status(1'b0, s);
               write_reg(ADDR_CTRL, '0);
               read_reg(ADDR_STATUS, s);
               read_reg(ADDR_DATA, r);
               if (r !== exp)
                  flag_error($sformatf("DATA %h while not full, expected %h", r, exp));
               read_reg(ADDR_STATUS, r);
               if (r[7:0] !== s[7:0])
                  flag_error($sformatf("Count moved from %0d to %0d", s[7:0], r[7:0]));
            end
            6: begin  // Soft reset while filling
               clean_start();
               write_reg(ADDR_CTRL, ctl);
               wait_status(1'b0, s);
               write_reg(ADDR_RESET, '0);
               read_reg(ADDR_CTRL, r);
               if (r !== exp)
                  flag_error($sformatf("CTRL %h after soft reset, expected %h", r, exp));
               read_reg(ADDR_STATUS, r);
               if (r !== exp)
                  flag_error($sformatf("STATUS %h after soft reset, expected %h", r, exp));
            end
            default: begin
               $display("Golden file holds unknown step code %h", code);
               errors++;
            end
         endcase
      end
      $display("Run complete, %0d errors", errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
